// File: tb.f
audio_ctrl_pkg.sv
payload_counter.sv
stream_config.sv
reply_writer.sv
ctrl_fsm.sv
audio_ctrl_top.sv
tb_fifo_models.sv
tb_audio_ctrl.sv

// File: tb_audio_ctrl.sv
// Testbench for the audio bridge control block
// Table of host commands with expected LEDs, audio bytes and status replies

`timescale 1ns/1ps

module tb_audio_ctrl;

    localparam int NSTEPS  = 8;
    localparam int TIMEOUT = 3000;

    logic       clk;
    logic       reset_i;
    logic       push;
    logic [7:0] push_data;
    logic       spdif_streaming;
    logic       i2s_streaming;

    logic       rd_in_fifo_en;
    logic       rd_in_fifo_empty;
    logic [7:0] rd_in_fifo_data;
    logic       wr_out_fifo_en;
    logic [7:0] wr_out_fifo_data;
    logic       wr_out_fifo_full;
    logic       wr_out_fifo_afull;
    logic       wr_spdif_en;
    logic       wr_i2s_en;
    logic [7:0] wr_audio_data;
    logic       spdif_full;
    logic       spdif_afull;
    logic       i2s_full;
    logic       i2s_afull;
    logic       led_err;
    logic [7:0] led_sr;
    logic [3:0] led_bd;
    logic [1:0] led_type;
    logic [1:0] led_streaming;

    // Table columns, byte 0 sits in the top bits
    int          n_host  [NSTEPS];
    logic [63:0] host    [NSTEPS];
    logic [7:0]  e_sr    [NSTEPS];
    logic [3:0]  e_bd    [NSTEPS];
    // Type LED, also the expected transmitter port
    logic [1:0]  e_type  [NSTEPS];
    logic        e_err   [NSTEPS];
    int          n_audio [NSTEPS];
    logic [63:0] e_audio [NSTEPS];
    int          n_reply [NSTEPS];
    logic [15:0] e_reply [NSTEPS];
    // Cycles the S/PDIF streaming flag stays high after the push
    int          hold    [NSTEPS];
    // Host bytes left unread at the end of the step
    int          n_left  [NSTEPS];

    int value_errors;
    int other_errors;
    int audio_base;
    int reply_base;

    audio_ctrl_top #(
        .SYNC_STAGES (2)
    ) DUT (
        .clk                 (clk),
        .reset_i             (reset_i),
        .rd_in_fifo_en_o     (rd_in_fifo_en),
        .rd_in_fifo_empty_i  (rd_in_fifo_empty),
        .rd_in_fifo_data_i   (rd_in_fifo_data),
        .wr_out_fifo_en_o    (wr_out_fifo_en),
        .wr_out_fifo_data_o  (wr_out_fifo_data),
        .wr_out_fifo_full_i  (wr_out_fifo_full),
        .wr_out_fifo_afull_i (wr_out_fifo_afull),
        .wr_spdif_en_o       (wr_spdif_en),
        .wr_i2s_en_o         (wr_i2s_en),
        .wr_audio_data_o     (wr_audio_data),
        .spdif_full_i        (spdif_full),
        .spdif_afull_i       (spdif_afull),
        .i2s_full_i          (i2s_full),
        .i2s_afull_i         (i2s_afull),
        .spdif_streaming_i   (spdif_streaming),
        .i2s_streaming_i     (i2s_streaming),
        .led_err_o           (led_err),
        .led_sr_o            (led_sr),
        .led_bd_o            (led_bd),
        .led_type_o          (led_type),
        .led_streaming_o     (led_streaming)
    );

    in_fifo_model in_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .push_i      (push),
        .push_data_i (push_data),
        .rd_en_i     (rd_in_fifo_en),
        .empty_o     (rd_in_fifo_empty),
        .data_o      (rd_in_fifo_data)
    );

    reply_sink replies (
        .clk     (clk),
        .reset_i (reset_i),
        .wr_en_i (wr_out_fifo_en),
        .data_i  (wr_out_fifo_data),
        .full_o  (wr_out_fifo_full),
        .afull_o (wr_out_fifo_afull)
    );

    audio_sink audio (
        .clk           (clk),
        .reset_i       (reset_i),
        .spdif_en_i    (wr_spdif_en),
        .i2s_en_i      (wr_i2s_en),
        .data_i        (wr_audio_data),
        .spdif_full_o  (spdif_full),
        .spdif_afull_o (spdif_afull),
        .i2s_full_o    (i2s_full),
        .i2s_afull_o   (i2s_afull)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================
    task automatic set_row(input int s, input int nh, input logic [63:0] hb,
                           input logic [7:0] sr, input logic [3:0] bd, input logic [1:0] typ,
                           input logic err, input int na, input logic [63:0] ab,
                           input int nr, input logic [15:0] rb, input int hd, input int left);
        n_host[s]  = nh;
        host[s]    = hb;
        e_sr[s]    = sr;
        e_bd[s]    = bd;
        e_type[s]  = typ;
        e_err[s]   = err;
        n_audio[s] = na;
        e_audio[s] = ab;
        n_reply[s] = nr;
        e_reply[s] = rb;
        hold[s]    = hd;
        n_left[s]  = left;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            value_errors++;
        end
    endtask

    // One byte per cycle into the host FIFO
    task automatic push_bytes(input int s);
        for (int i = 0; i < n_host[s]; i++) begin
            @(posedge clk);
            push      <= 1'b1;
            push_data <= host[s][63 - 8*i -: 8];
        end
        @(posedge clk);
        push <= 1'b0;
    endtask

    function automatic logic step_done(input int s);
        return in_fifo.level == n_left[s] && audio.count == audio_base + n_audio[s]
            && replies.count == reply_base + n_reply[s] && led_sr == e_sr[s]
            && led_bd == e_bd[s] && led_type == e_type[s] && led_err == e_err[s];
    endfunction

    task automatic wait_step(input int s);
        int cycles;
        cycles = 0;
        while (!step_done(s) && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (step_done(s)) else begin
            $display("Step %0d timed out waiting for the DUT to finish", s);
            other_errors++;
        end
    endtask

    task automatic check_step(input int s);
        check_value("led_sr_o", led_sr, e_sr[s]);
        check_value("led_bd_o", led_bd, e_bd[s]);
        check_value("led_type_o", led_type, e_type[s]);
        check_value("led_err_o", led_err, e_err[s]);
        for (int i = 0; i < n_audio[s]; i++) begin
            check_value("wr_audio_data_o", audio.bytes[audio_base + i],
                        e_audio[s][63 - 8*i -: 8]);
            check_value("{wr_i2s_en_o, wr_spdif_en_o}", audio.ports[audio_base + i], e_type[s]);
        end
        for (int i = 0; i < n_reply[s]; i++) begin
            check_value("wr_out_fifo_data_o", replies.bytes[reply_base + i],
                        e_reply[s][15 - 8*i -: 8]);
        end
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        reset_i         = 1'b1;
        push            = 1'b0;
        push_data       = 8'h00;
        spdif_streaming = 1'b0;
        i2s_streaming   = 1'b0;
        value_errors    = 0;
        other_errors    = 0;

        // Reset state, nothing configured
        set_row(0, 0, 64'h0, 8'h00, 4'h0, 2'b00, 1'b0, 0, 64'h0, 0, 16'h0, 0, 0);
        // I2S, rate code 5, depth 24-bit
        set_row(1, 2, 64'h01_16_00_00_00_00_00_00, 8'h20, 4'h4, 2'b10, 1'b0,
                0, 64'h0, 0, 16'h0, 0, 0);
        set_row(2, 7, 64'h86_11_22_33_44_55_66_00, 8'h20, 4'h4, 2'b10, 1'b0,
                6, 64'h11_22_33_44_55_66_00_00, 0, 16'h0, 0, 0);
        // S/PDIF, rate code 2, depth 32-bit
        set_row(3, 2, 64'h01_8B_00_00_00_00_00_00, 8'h04, 4'h8, 2'b01, 1'b0,
                0, 64'h0, 0, 16'h0, 0, 0);
        set_row(4, 8, 64'h87_A1_B2_C3_D4_E5_F6_07, 8'h04, 4'h8, 2'b01, 1'b0,
                7, 64'hA1_B2_C3_D4_E5_F6_07_00, 0, 16'h0, 0, 0);
        // Good STOP, reply after streaming ends
        set_row(5, 1, 64'hC0_00_00_00_00_00_00_00, 8'h04, 4'h8, 2'b01, 1'b0,
                0, 64'h0, 2, 16'hC1_00, 24, 0);
        // Input setup dropped, then I2S at rate code 7, depth 16-bit
        set_row(6, 5, 64'h42_AA_55_01_1D_00_00_00, 8'h80, 4'h2, 2'b10, 1'b0,
                0, 64'h0, 0, 16'h0, 0, 0);
        // STOP with a payload, later bytes stay in the FIFO
        set_row(7, 4, 64'hC2_01_16_86_00_00_00_00, 8'h80, 4'h2, 2'b10, 1'b1,
                0, 64'h0, 2, 16'hC1_02, 0, 3);

        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        check_value("rd_in_fifo_en_o", rd_in_fifo_en, 1'b0);
        check_value("wr_out_fifo_en_o", wr_out_fifo_en, 1'b0);
        check_value("wr_spdif_en_o", wr_spdif_en, 1'b0);
        check_value("wr_i2s_en_o", wr_i2s_en, 1'b0);
        check_value("led_streaming_o", led_streaming, 2'b00);

        for (int s = 0; s < NSTEPS; s++) begin
            audio_base = audio.count;
            reply_base = replies.count;
            if (hold[s] > 0) begin
                @(posedge clk);
                spdif_streaming <= 1'b1;
            end
            push_bytes(s);
            if (hold[s] > 0) begin
                repeat (hold[s]) @(posedge clk);
                check_value("led_streaming_o", led_streaming, 2'b01);
                check_value("reply bytes before streaming ended", replies.count - reply_base, 0);
                spdif_streaming <= 1'b0;
            end
            wait_step(s);
            check_step(s);
        end

        // Parked after the error reply
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            assert (!rd_in_fifo_en) else begin
                $display("Read enable went high while parked after an error");
                other_errors++;
            end
        end
        check_value("host FIFO bytes left", in_fifo.level, n_left[NSTEPS-1]);
        check_value("writes under back-pressure", audio.bp_errors, 0);

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb_fifo_models.sv
// Testbench models for the host FIFOs and the audio transmitters
// Input FIFO with 1-cycle read latency, reply capture, audio capture with back-pressure

`timescale 1ns/1ps

// ============================================================
// Host input FIFO
// ============================================================
module in_fifo_model (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       push_i,
    input  logic [7:0] push_data_i,
    input  logic       rd_en_i,
    output logic       empty_o,
    output logic [7:0] data_o
);

    logic [7:0] q [$];
    // Bytes still waiting in the FIFO
    int         level;

    initial begin
        empty_o = 1'b1;
        data_o  = 8'h00;
        level   = 0;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            q.delete();
            empty_o <= 1'b1;
            level   <= 0;
        end else begin
            // Data shows up the cycle after the read
            if (rd_en_i && !empty_o) begin
                data_o <= q.pop_front();
            end
            if (push_i) begin
                q.push_back(push_data_i);
            end
            empty_o <= (q.size() == 0);
            level   <= q.size();
        end
    end

endmodule

// ============================================================
// Host output FIFO, never full
// ============================================================
module reply_sink (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       wr_en_i,
    input  logic [7:0] data_i,
    output logic       full_o,
    output logic       afull_o
);

    logic [7:0] bytes [16];
    int         count;

    initial begin
        full_o  = 1'b0;
        afull_o = 1'b0;
        count   = 0;
    end

    always @(posedge clk) begin
        if (!reset_i && wr_en_i && count < 16) begin
            bytes[count] <= data_i;
            count        <= count + 1;
        end
    end

endmodule

// ============================================================
// Transmitter write ports with random back-pressure
// ============================================================
module audio_sink (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       spdif_en_i,
    input  logic       i2s_en_i,
    input  logic [7:0] data_i,
    output logic       spdif_full_o,
    output logic       spdif_afull_o,
    output logic       i2s_full_o,
    output logic       i2s_afull_o
);

    logic [7:0]  bytes [64];
    // Write enables seen with each byte, {i2s, spdif}
    logic [1:0]  ports [64];
    int          count;
    int          bp_errors;
    logic [31:0] lfsr_q;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    initial begin
        spdif_full_o  = 1'b0;
        spdif_afull_o = 1'b0;
        i2s_full_o    = 1'b0;
        i2s_afull_o   = 1'b0;
        count         = 0;
        bp_errors     = 0;
        lfsr_q        = 32'hdd57_6393;
    end

    always @(posedge clk) begin : bp_gen
        logic [31:0] s;
        logic [9:0]  b;
        s = lfsr_q;
        // One step per bit taken
        for (int k = 0; k < 10; k++) begin
            s    = lfsr_step(s);
            b[k] = s[0];
        end
        lfsr_q        <= s;
        spdif_afull_o <= b[0] & b[1];
        spdif_full_o  <= b[2] & b[3] & b[4];
        i2s_afull_o   <= b[5] & b[6];
        i2s_full_o    <= b[7] & b[8] & b[9];
        if (!reset_i && (spdif_en_i || i2s_en_i) && count < 64) begin
            bytes[count] <= data_i;
            ports[count] <= {i2s_en_i, spdif_en_i};
            count        <= count + 1;
        end
        // Write while the target reports full or almost-full
        if ((spdif_en_i && (spdif_full_o || spdif_afull_o))
            || (i2s_en_i && (i2s_full_o || i2s_afull_o))) begin
            bp_errors <= bp_errors + 1;
        end
    end

endmodule

// File: audio_ctrl_top.sv
// Audio bridge control top level
// Host FIFO command decode, transmitter write port, status reply and LEDs

`timescale 1ns/1ps

module audio_ctrl_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  reset_i,
    // Host input FIFO
    output logic                  rd_in_fifo_en_o,
    input  logic                  rd_in_fifo_empty_i,
    input  audio_ctrl_pkg::byte_t rd_in_fifo_data_i,
    // Host output FIFO
    output logic                  wr_out_fifo_en_o,
    output audio_ctrl_pkg::byte_t wr_out_fifo_data_o,
    input  logic                  wr_out_fifo_full_i,
    input  logic                  wr_out_fifo_afull_i,
    // Transmitter write port
    output logic                  wr_spdif_en_o,
    output logic                  wr_i2s_en_o,
    output audio_ctrl_pkg::byte_t wr_audio_data_o,
    input  logic                  spdif_full_i,
    input  logic                  spdif_afull_i,
    input  logic                  i2s_full_i,
    input  logic                  i2s_afull_i,
    input  logic                  spdif_streaming_i,
    input  logic                  i2s_streaming_i,
    // Status LEDs
    output logic                  led_err_o,
    output logic [7:0]            led_sr_o,
    output logic [3:0]            led_bd_o,
    output logic [1:0]            led_type_o,
    output logic [1:0]            led_streaming_o
);

    // FSM to protocol tracker
    logic                  byte_valid;
    audio_ctrl_pkg::byte_t fsm_byte;
    logic                  in_payload;
    audio_ctrl_pkg::cmd_t  last_cmd;
    // FSM to output configuration
    logic                  setup_wr;
    logic                  stream_wr;
    logic                  out_busy;
    logic                  streaming;
    // FSM to reply writer
    logic                  reply_start;
    audio_ctrl_pkg::err_t  reply_err;
    logic                  reply_done;

    ctrl_fsm u_ctrl_fsm (
        .clk                (clk),
        .reset_i            (reset_i),
        .rd_in_fifo_en_o    (rd_in_fifo_en_o),
        .rd_in_fifo_empty_i (rd_in_fifo_empty_i),
        .rd_in_fifo_data_i  (rd_in_fifo_data_i),
        .in_payload_i       (in_payload),
        .last_cmd_i         (last_cmd),
        .out_busy_i         (out_busy),
        .streaming_i        (streaming),
        .reply_done_i       (reply_done),
        .byte_valid_o       (byte_valid),
        .byte_o             (fsm_byte),
        .setup_wr_o         (setup_wr),
        .stream_wr_o        (stream_wr),
        .reply_start_o      (reply_start),
        .reply_err_o        (reply_err),
        .led_err_o          (led_err_o)
    );

    payload_counter u_payload_counter (
        .clk          (clk),
        .reset_i      (reset_i),
        .byte_valid_i (byte_valid),
        .byte_i       (fsm_byte),
        .in_payload_o (in_payload),
        .last_cmd_o   (last_cmd)
    );

    stream_config #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_stream_config (
        .clk               (clk),
        .reset_i           (reset_i),
        .setup_wr_i        (setup_wr),
        .stream_wr_i       (stream_wr),
        .byte_i            (fsm_byte),
        .spdif_full_i      (spdif_full_i),
        .spdif_afull_i     (spdif_afull_i),
        .i2s_full_i        (i2s_full_i),
        .i2s_afull_i       (i2s_afull_i),
        .spdif_streaming_i (spdif_streaming_i),
        .i2s_streaming_i   (i2s_streaming_i),
        .wr_spdif_en_o     (wr_spdif_en_o),
        .wr_i2s_en_o       (wr_i2s_en_o),
        .wr_audio_data_o   (wr_audio_data_o),
        .out_busy_o        (out_busy),
        .streaming_o       (streaming),
        .led_sr_o          (led_sr_o),
        .led_bd_o          (led_bd_o),
        .led_type_o        (led_type_o),
        .led_streaming_o   (led_streaming_o)
    );

    reply_writer u_reply_writer (
        .clk                 (clk),
        .reset_i             (reset_i),
        .reply_start_i       (reply_start),
        .reply_err_i         (reply_err),
        .wr_out_fifo_full_i  (wr_out_fifo_full_i),
        .wr_out_fifo_afull_i (wr_out_fifo_afull_i),
        .wr_out_fifo_en_o    (wr_out_fifo_en_o),
        .wr_out_fifo_data_o  (wr_out_fifo_data_o),
        .reply_done_o        (reply_done)
    );

endmodule

// File: ctrl_fsm.sv
// Main control FSM
// Reads the host FIFO, dispatches headers and payload, sequences stop and error

`timescale 1ns/1ps

module ctrl_fsm (
    input  logic                  clk,
    input  logic                  reset_i,
    output logic                  rd_in_fifo_en_o,
    input  logic                  rd_in_fifo_empty_i,
    input  audio_ctrl_pkg::byte_t rd_in_fifo_data_i,
    input  logic                  in_payload_i,
    input  audio_ctrl_pkg::cmd_t  last_cmd_i,
    input  logic                  out_busy_i,
    input  logic                  streaming_i,
    input  logic                  reply_done_i,
    output logic                  byte_valid_o,
    output audio_ctrl_pkg::byte_t byte_o,
    output logic                  setup_wr_o,
    output logic                  stream_wr_o,
    output logic                  reply_start_o,
    output audio_ctrl_pkg::err_t  reply_err_o,
    output logic                  led_err_o
);

    typedef enum logic [1:0] {IDLE, RD, WR_REPLY, WAIT_STOP} state_t;

    state_t                state_q;
    // Byte on the FIFO data lines this cycle
    logic                  rd_pending_q;
    // Read-ahead byte parked while the transmitter was busy
    logic                  have_saved_q;
    audio_ctrl_pkg::byte_t saved_q;

    audio_ctrl_pkg::cmd_t  hdr_cmd;
    audio_ctrl_pkg::len_t  hdr_len;
    logic                  consume;
    logic                  hdr_take;
    logic                  hdr_stop;
    logic                  hdr_err;
    logic                  stop_done;

    // ============================================================
    // Byte source and consume condition
    // ============================================================
    // Saved byte always goes first
    assign byte_o       = have_saved_q ? saved_q : rd_in_fifo_data_i;
    assign hdr_cmd      = byte_o[7:6];
    assign hdr_len      = byte_o[5:0];
    assign consume      = (state_q == RD) && (have_saved_q || rd_pending_q) && !out_busy_i;
    assign byte_valid_o = consume;
    assign hdr_take     = consume && !in_payload_i;

    // Header checks
    always_comb begin
        hdr_stop    = 1'b0;
        hdr_err     = 1'b0;
        reply_err_o = audio_ctrl_pkg::ERROR_NONE;
        if (hdr_take) begin
            case (hdr_cmd)
                audio_ctrl_pkg::CMD_SETUP_OUTPUT: begin
                    if (hdr_len != 6'd1) begin
                        hdr_err     = 1'b1;
                        reply_err_o = audio_ctrl_pkg::ERROR_SETUP_PAYLOAD;
                    end
                end
                audio_ctrl_pkg::CMD_STOP: begin
                    if (hdr_len != 6'd0) begin
                        hdr_err     = 1'b1;
                        reply_err_o = audio_ctrl_pkg::ERROR_STOP_PAYLOAD;
                    end else begin
                        hdr_stop = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // Payload routing by the latched command
    always_comb begin
        setup_wr_o  = 1'b0;
        stream_wr_o = 1'b0;
        if (consume && in_payload_i) begin
            case (last_cmd_i)
                audio_ctrl_pkg::CMD_SETUP_OUTPUT:  setup_wr_o  = 1'b1;
                audio_ctrl_pkg::CMD_STREAM_OUTPUT: stream_wr_o = 1'b1;
                // Input setup is not supported, bytes are dropped
                audio_ctrl_pkg::CMD_SETUP_INPUT:   ;
                default: ;
            endcase
        end
    end

    assign stop_done     = (state_q == WAIT_STOP) && !streaming_i;
    assign reply_start_o = hdr_err || stop_done;

    // Read only with no saved byte and the transmitter free
    // No read-ahead past a STOP or bad header, later bytes stay in the FIFO
    assign rd_in_fifo_en_o = (state_q == RD) && !rd_in_fifo_empty_i && !out_busy_i
                           && !have_saved_q && !hdr_stop && !hdr_err;

    // ============================================================
    // State and read-ahead registers
    // ============================================================
    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            state_q      <= RD;
            rd_pending_q <= 1'b0;
            have_saved_q <= 1'b0;
            led_err_o    <= 1'b0;
        end else begin
            rd_pending_q <= rd_in_fifo_en_o;

            if (consume && have_saved_q) begin
                have_saved_q <= 1'b0;
            end else if (rd_pending_q && !consume) begin
                have_saved_q <= 1'b1;
            end

            case (state_q)
                RD: begin
                    if (hdr_err) begin
                        state_q   <= WR_REPLY;
                        led_err_o <= 1'b1;
                    end else if (hdr_stop) begin
                        state_q <= WAIT_STOP;
                    end
                end
                WAIT_STOP: begin
                    if (stop_done) begin
                        state_q <= WR_REPLY;
                    end
                end
                WR_REPLY: begin
                    // Error replies park the block until reset
                    if (reply_done_i) begin
                        state_q <= led_err_o ? IDLE : RD;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending_q && !consume) begin
            saved_q <= rd_in_fifo_data_i;
        end
    end

    // Once an error is flagged the block is parked and never reads the host FIFO
    assert property (@(posedge clk) disable iff (reset_i)
        led_err_o |-> !rd_in_fifo_en_o);

endmodule

// File: reply_writer.sv
// Two-byte status reply to the host output FIFO
// Header byte then error code, paced by full and almost-full

`timescale 1ns/1ps

module reply_writer (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  reply_start_i,
    input  audio_ctrl_pkg::err_t  reply_err_i,
    input  logic                  wr_out_fifo_full_i,
    input  logic                  wr_out_fifo_afull_i,
    output logic                  wr_out_fifo_en_o,
    output audio_ctrl_pkg::byte_t wr_out_fifo_data_o,
    output logic                  reply_done_o
);

    audio_ctrl_pkg::byte_t reply_q [2];
    logic                  active_q;
    // Index of the next byte to send
    logic                  idx_q;

    assign wr_out_fifo_en_o   = active_q && !wr_out_fifo_full_i && !wr_out_fifo_afull_i;
    assign wr_out_fifo_data_o = reply_q[idx_q];

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            active_q     <= 1'b0;
            idx_q        <= 1'b0;
            reply_done_o <= 1'b0;
        end else begin
            reply_done_o <= 1'b0;
            if (reply_start_i) begin
                active_q <= 1'b1;
                idx_q    <= 1'b0;
            end else if (wr_out_fifo_en_o) begin
                idx_q <= !idx_q;
                // Second byte out, done follows next cycle
                if (idx_q) begin
                    active_q     <= 1'b0;
                    reply_done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reply_start_i) begin
            reply_q[0] <= {audio_ctrl_pkg::CMD_STOPPED, audio_ctrl_pkg::REPLY_LEN};
            reply_q[1] <= reply_err_i;
        end
    end

    // A new reply never starts while the previous one is still going out
    assert property (@(posedge clk) disable iff (reset_i)
        reply_start_i |-> !active_q);

endmodule

// File: stream_config.sv
// Output configuration and transmitter write port
// Setup registers, streaming flag synchronizers and status LED decode

`timescale 1ns/1ps

module stream_config #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  setup_wr_i,
    input  logic                  stream_wr_i,
    input  audio_ctrl_pkg::byte_t byte_i,
    input  logic                  spdif_full_i,
    input  logic                  spdif_afull_i,
    input  logic                  i2s_full_i,
    input  logic                  i2s_afull_i,
    input  logic                  spdif_streaming_i,
    input  logic                  i2s_streaming_i,
    output logic                  wr_spdif_en_o,
    output logic                  wr_i2s_en_o,
    output audio_ctrl_pkg::byte_t wr_audio_data_o,
    output logic                  out_busy_o,
    output logic                  streaming_o,
    output logic [7:0]            led_sr_o,
    output logic [3:0]            led_bd_o,
    output logic [1:0]            led_type_o,
    output logic [1:0]            led_streaming_o
);

    // Bit positions in the output enable vector
    localparam int TYPE_SPDIF = 0;
    localparam int TYPE_I2S   = 1;

    logic [1:0]                   io_en_q;
    audio_ctrl_pkg::sample_rate_t sample_rate_q;
    audio_ctrl_pkg::bit_depth_t   bit_depth_q;
    // Byte waiting for the enabled transmitter
    logic                         wr_pend_q;
    audio_ctrl_pkg::byte_t        data_q;
    // SYNC_STAGES must be at least 2
    logic [SYNC_STAGES-1:0]       spdif_sync_q;
    logic [SYNC_STAGES-1:0]       i2s_sync_q;
    logic [1:0]                   tx_busy;
    logic                         wr_go;

    // ============================================================
    // Back-pressure and write port
    // ============================================================
    assign tx_busy    = {i2s_full_i | i2s_afull_i, spdif_full_i | spdif_afull_i};
    assign out_busy_o = |(tx_busy & io_en_q);

    // Normally fires the cycle after stream_wr, held while busy
    assign wr_go           = wr_pend_q && !out_busy_o;
    assign wr_spdif_en_o   = wr_go && io_en_q[TYPE_SPDIF];
    assign wr_i2s_en_o     = wr_go && io_en_q[TYPE_I2S];
    assign wr_audio_data_o = data_q;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            io_en_q       <= 2'b00;
            sample_rate_q <= '0;
            bit_depth_q   <= '0;
            wr_pend_q     <= 1'b0;
            spdif_sync_q  <= '0;
            i2s_sync_q    <= '0;
        end else begin
            if (setup_wr_i) begin
                // Select codes 0/1 go to I2S, 2/3 to S/PDIF
                io_en_q <= byte_i[audio_ctrl_pkg::SETUP_SEL_BIT] ? 2'b01 : 2'b10;
                sample_rate_q <= byte_i[audio_ctrl_pkg::SETUP_SR_LSB +:
                                        $bits(audio_ctrl_pkg::sample_rate_t)];
                bit_depth_q <= byte_i[audio_ctrl_pkg::SETUP_BD_LSB +:
                                      $bits(audio_ctrl_pkg::bit_depth_t)];
            end
            // New byte only arrives while not busy, so the old one drains the same cycle
            wr_pend_q    <= stream_wr_i || (wr_pend_q && out_busy_o);
            spdif_sync_q <= {spdif_sync_q[SYNC_STAGES-2:0], spdif_streaming_i};
            i2s_sync_q   <= {i2s_sync_q[SYNC_STAGES-2:0], i2s_streaming_i};
        end
    end

    always_ff @(posedge clk) begin
        if (stream_wr_i) begin
            data_q <= byte_i;
        end
    end

    // ============================================================
    // Status LEDs
    // ============================================================
    // Rate and depth only show once an output is configured
    assign led_sr_o        = (|io_en_q) ? (8'd1 << sample_rate_q) : 8'd0;
    assign led_bd_o        = (|io_en_q) ? (4'd1 << bit_depth_q) : 4'd0;
    assign led_type_o      = io_en_q;
    assign led_streaming_o = {i2s_sync_q[SYNC_STAGES-1], spdif_sync_q[SYNC_STAGES-1]};
    assign streaming_o     = |led_streaming_o;

    // A new stream byte never overwrites one still held back by the transmitter
    assert property (@(posedge clk) disable iff (reset_i)
        stream_wr_i |-> !(wr_pend_q && out_busy_o));

endmodule

// File: payload_counter.sv
// Header and payload phase tracker
// Latches the command and counts payload bytes down to the next header

`timescale 1ns/1ps

module payload_counter (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  byte_valid_i,
    input  audio_ctrl_pkg::byte_t byte_i,
    output logic                  in_payload_o,
    output audio_ctrl_pkg::cmd_t  last_cmd_o
);

    audio_ctrl_pkg::len_t count_q;

    always_ff @(posedge clk or posedge reset_i) begin
        if (reset_i) begin
            in_payload_o <= 1'b0;
            count_q      <= '0;
            last_cmd_o   <= audio_ctrl_pkg::CMD_SETUP_OUTPUT;
        end else if (byte_valid_i) begin
            if (!in_payload_o) begin
                // Zero-length headers stay in the header phase
                if (byte_i[5:0] != 6'd0) begin
                    in_payload_o <= 1'b1;
                    count_q      <= byte_i[5:0];
                    last_cmd_o   <= byte_i[7:6];
                end
            end else begin
                count_q <= count_q - 6'd1;
                if (count_q == 6'd1) begin
                    in_payload_o <= 1'b0;
                end
            end
        end
    end

endmodule

// File: audio_ctrl_pkg.sv
// Audio bridge control package
// Host protocol codes, field widths and the setup payload layout

package audio_ctrl_pkg;

    // ============================================================
    // Field types
    // ============================================================
    typedef logic [7:0] byte_t;
    // Header bits 7..6
    typedef logic [1:0] cmd_t;
    // Header bits 5..0, also the payload counter
    typedef logic [5:0] len_t;
    // Bit 2 set selects the 48 kHz family
    typedef logic [2:0] sample_rate_t;
    // 0 DoP, 1 16-bit, 2 24-bit, 3 32-bit
    typedef logic [1:0] bit_depth_t;
    typedef logic [7:0] err_t;

    // ============================================================
    // Protocol codes
    // ============================================================
    localparam cmd_t CMD_SETUP_OUTPUT  = 2'd0;
    localparam cmd_t CMD_SETUP_INPUT   = 2'd1;
    localparam cmd_t CMD_STREAM_OUTPUT = 2'd2;
    localparam cmd_t CMD_STOP          = 2'd3;

    // Status reply header, a single payload byte follows
    localparam cmd_t CMD_STOPPED = 2'd3;
    localparam len_t REPLY_LEN   = 6'd1;

    localparam err_t ERROR_NONE          = 8'd0;
    localparam err_t ERROR_SETUP_PAYLOAD = 8'd1;
    localparam err_t ERROR_STOP_PAYLOAD  = 8'd2;

    // Setup payload layout
    // Select codes 2 and 3 mean S/PDIF, so bit 7 alone picks the type
    localparam int SETUP_SEL_BIT = 7;
    localparam int SETUP_SR_LSB  = 2;
    localparam int SETUP_BD_LSB  = 0;

endpackage
